// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing
TOP       = line_render_tb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/line_input.txt
# D or X: addr data name. B: addr word on off first last name. T: addr word palette first last name
# E: addr value name. An X line tries a direct write while the command above it is busy
D 000 0011 direct_lo
D 4ff 00a5 direct_last
D 100 0021 guard_lo
D 105 0022 guard_hi
D 202 0066 guard_tile
B 0a0 00b4 0f 01 8 0 bitmap_full
X 000 00ee busy_poke
B 101 0096 33 44 6 2 bitmap_part
T 200 dcba 7 3 1 tile_skip
T 210 4321 c 4 0 tile_noskip
E 000 11 busy_poke
E 4ff a5 direct_last
E 0a0 0f bitmap_full
E 0a1 01 bitmap_full
E 0a2 0f bitmap_full
E 0a3 0f bitmap_full
E 0a4 01 bitmap_full
E 0a5 0f bitmap_full
E 0a6 01 bitmap_full
E 0a7 01 bitmap_full
E 100 21 guard_lo
E 101 44 bitmap_part
E 102 33 bitmap_part
E 103 44 bitmap_part
E 104 33 bitmap_part
E 105 22 guard_hi
E 200 7b tile_skip
E 201 7c tile_skip
E 202 66 guard_tile
E 210 c1 tile_noskip
E 211 c2 tile_noskip
E 212 c3 tile_noskip
E 213 c4 tile_noskip

// File: dv/line_render_tb.sv
`timescale 1ns/1ps
`default_nettype none

module line_render_tb import line_pkg::*; ();

   localparam int    max_cmds     = 32;
   localparam int    max_exps     = 64;
   localparam int    reset_cycles = 16;
   localparam int    margin       = 64;
   localparam string input_file   = "dv/line_input.txt";

   wire                 wr_clk;
   wire                 rd_clk;
   wire                 reset_n;
   wire  [pix_w-1:0]    rd_data;
   wire                 wr_busy;
   logic [addr_w-1:0]   rd_addr;
   logic                wr_en;
   logic [addr_w-1:0]   wr_addr;
   line_word_t          wr_data;
   logic [pix_w-1:0]    wr_bitmap_on;
   logic [pix_w-1:0]    wr_bitmap_off;
   logic [bm_idx_w-1:0] wr_bitmap_first;
   logic [bm_idx_w-1:0] wr_bitmap_last;
   logic [tl_idx_w-1:0] wr_tile_pixel_first;
   logic [tl_idx_w-1:0] wr_tile_pixel_last;
   logic [pal_w-1:0]    wr_tile_palette;

   string               cmd_kind  [max_cmds];
   string               cmd_name  [max_cmds];
   logic [addr_w-1:0]   cmd_addr  [max_cmds];
   logic [15:0]         cmd_data  [max_cmds];
   logic [pix_w-1:0]    cmd_on    [max_cmds];
   logic [pix_w-1:0]    cmd_off   [max_cmds];
   logic [3:0]          cmd_first [max_cmds];
   logic [3:0]          cmd_last  [max_cmds];
   logic [pal_w-1:0]    cmd_pal   [max_cmds];
   logic [addr_w-1:0]   exp_addr  [max_exps];
   logic [pix_w-1:0]    exp_value [max_exps];
   string               exp_name  [max_exps];
   logic [pix_w-1:0]    line_copy [line_len];
   int                  num_cmds = 0;
   int                  num_exps = 0;
   int                  seed;
   int                  cycle_count = 0;
   int                  cycle_limit = 0;

   tb_clock_gen clocks (
      .wr_clk  (wr_clk),
      .rd_clk  (rd_clk),
      .reset_n (reset_n)
   );

   line_render_top dut (
      .reset_n             (reset_n),
      .wr_clk              (wr_clk),
      .rd_clk              (rd_clk),
      .rd_addr             (rd_addr),
      .wr_en               (wr_en),
      .wr_addr             (wr_addr),
      .wr_data             (wr_data),
      .wr_bitmap_on        (wr_bitmap_on),
      .wr_bitmap_off       (wr_bitmap_off),
      .wr_bitmap_first     (wr_bitmap_first),
      .wr_bitmap_last      (wr_bitmap_last),
      .wr_tile_pixel_first (wr_tile_pixel_first),
      .wr_tile_pixel_last  (wr_tile_pixel_last),
      .wr_tile_palette     (wr_tile_palette),
      .rd_data             (rd_data),
      .wr_busy             (wr_busy)
   );

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
         $display("SOME TESTS FAILED");
         $fatal(1, "check failed");
      end
   endtask

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("SOME TESTS FAILED");
      $fatal(1, "run aborted");
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stimulus file
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic load_input();
      int    fd;
      int    n;
      int    want;
      int    a, b, c, d, e, f, g;
      string line;
      string kind;
      string name;
      fd = $fopen(input_file, "r");
      if (fd == 0) begin
         stop_on_error({"Could not open ", input_file, " for reading"});
      end
      while (!$feof(fd)) begin
         line = "";
         kind = "";
         want = 0;
         a = 0;
         b = 0;
         c = 0;
         d = 0;
         e = 0;
         f = 0;
         g = 0;
         n = $fgets(line, fd);
         if (n > 0) begin
            n = $sscanf(line, "%s", kind);
         end
         if (kind == "D" || kind == "X" || kind == "E") begin
            want = 4;
            n = $sscanf(line, "%s %h %h %s", kind, a, b, name);
         end else if (kind == "B") begin
            want = 8;
            n = $sscanf(line, "%s %h %h %h %h %h %h %s", kind, a, b, c, d, e, f, name);
         end else if (kind == "T") begin
            want = 7;
            n = $sscanf(line, "%s %h %h %h %h %h %s", kind, a, b, g, e, f, name);
         end else if (kind != "" && kind != "#") begin
            stop_on_error({"Unknown line kind in stimulus file: ", kind});
         end
         if (want > 0 && n != want) begin
            stop_on_error({"Malformed stimulus line: ", line});
         end
         if (num_cmds >= max_cmds || num_exps >= max_exps) begin
            stop_on_error("Stimulus file holds more lines than the testbench can store");
         end
         if (kind == "E") begin
            exp_addr[num_exps]  = addr_w'(a);
            exp_value[num_exps] = pix_w'(b);
            exp_name[num_exps]  = name;
            num_exps++;
         end else if (want > 0) begin
            cmd_kind[num_cmds]  = kind;
            cmd_name[num_cmds]  = name;
            cmd_addr[num_cmds]  = addr_w'(a);
            cmd_data[num_cmds]  = 16'(b);
            cmd_on[num_cmds]    = pix_w'(c);
            cmd_off[num_cmds]   = pix_w'(d);
            cmd_first[num_cmds] = 4'(e);
            cmd_last[num_cmds]  = 4'(f);
            cmd_pal[num_cmds]   = pal_w'(g);
            num_cmds++;
         end
      end
      $fclose(fd);
   endtask

   // Busy length in cycles. Busy drops one cycle after the last pixel.
   function automatic int busy_cycles_for(input int i);
      int first;
      int last;
      first = int'(cmd_first[i]);
      last  = int'(cmd_last[i]);
      if (cmd_kind[i] == "B") begin
         return first - last + 1;
      end else if (cmd_kind[i] == "T") begin
         if (first == last) begin
            return 1;  // Nothing to skip or write.
         end
         return (4 - first) + (first - last) + 1;  // Skipped nibbles.
      end
      return 0;
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Drivers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic drive_idle();
      wr_en               = 1'b0;
      wr_addr             = '0;
      wr_data             = '0;
      wr_bitmap_on        = '0;
      wr_bitmap_off       = '0;
      wr_bitmap_first     = '0;
      wr_bitmap_last      = '0;
      wr_tile_pixel_first = '0;
      wr_tile_pixel_last  = '0;
      wr_tile_palette     = '0;
   endtask

   task automatic drive_command(input int i);
      drive_idle();
      wr_addr = cmd_addr[i];
      wr_data = cmd_data[i];
      if (cmd_kind[i] == "B") begin
         wr_bitmap_on    = cmd_on[i];
         wr_bitmap_off   = cmd_off[i];
         wr_bitmap_first = bm_idx_w'(cmd_first[i]);
         wr_bitmap_last  = bm_idx_w'(cmd_last[i]);
      end else if (cmd_kind[i] == "T") begin
         wr_tile_pixel_first = tl_idx_w'(cmd_first[i]);
         wr_tile_pixel_last  = tl_idx_w'(cmd_last[i]);
         wr_tile_palette     = cmd_pal[i];
      end
      wr_en = 1'b1;
   endtask

   task automatic run_command(input int i, input bit poke);
      int busy_len;
      int gap;
      gap = {$random(seed)} % 4;
      repeat (gap) @(negedge wr_clk);
      check_value({cmd_name[i], " idle before issue"}, 0, 32'(wr_busy));
      drive_command(i);
      @(negedge wr_clk);  // Taken at the rising edge in between.
      drive_idle();
      busy_len = 0;
      if (poke) begin
         check_value({cmd_name[i + 1], " busy at poke"}, 1, 32'(wr_busy));
         drive_command(i + 1);
         busy_len = 1;
         @(negedge wr_clk);
         drive_idle();
      end
      while (wr_busy === 1'b1) begin
         busy_len++;
         @(negedge wr_clk);
      end
      check_value({cmd_name[i], " busy cycles"}, busy_cycles_for(i), busy_len);
   endtask

   // Pipelined read of one address per rd_clk cycle.
   task automatic read_line();
      for (int a = 0; a <= line_len; a++) begin
         @(negedge rd_clk);
         if (a > 0) begin
            line_copy[a - 1] = rd_data;
         end
         if (a < line_len) begin
            rd_addr = addr_w'(a);
         end
      end
   endtask

   always @(posedge wr_clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_limit > 0 && cycle_count > cycle_limit) begin
         $display("Timeout: the run did not finish within %0d write clock cycles",
                  cycle_limit);
         $display("SOME TESTS FAILED");
         $fatal(1, "timeout");
      end
   end

   initial begin
      int i;
      int limit;
      bit poke;
      seed    = 70;
      rd_addr = '0;
      drive_idle();
      load_input();
      limit = reset_cycles + line_len + 1 + margin;
      for (int k = 0; k < num_cmds; k++) begin
         limit += busy_cycles_for(k) + 7;  // Pixels, skip, gap and issue.
      end
      cycle_limit = limit;

      @(negedge wr_clk);
      while (reset_n !== 1'b1) begin
         check_value("reset", 0, 32'(wr_busy));
         @(negedge wr_clk);
      end
      check_value("reset release", 0, 32'(wr_busy));

      i = 0;
      while (i < num_cmds) begin
         poke = (cmd_kind[i] == "B" || cmd_kind[i] == "T") &&
                (i + 1 < num_cmds) && (cmd_kind[i + 1] == "X");
         run_command(i, poke);
         i += poke ? 2 : 1;
      end

      read_line();
      for (int k = 0; k < num_exps; k++) begin
         check_value(exp_name[k], 32'(exp_value[k]), 32'(line_copy[exp_addr[k]]));
      end

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic wr_clk,
   output logic rd_clk,
   output logic reset_n
);

   localparam int reset_cycles = 16;

   initial begin
      wr_clk = 1'b0;
      forever #5 wr_clk = ~wr_clk;  // 10 ns period.
   end

   initial begin
      rd_clk = 1'b0;
      forever #5 rd_clk = ~rd_clk;
   end

   initial begin
      reset_n = 1'b0;
      repeat (reset_cycles) @(negedge wr_clk);
      reset_n = 1'b1;  // Released on a falling edge.
   end

endmodule

`default_nettype wire

// File: rtl/bitmap_expander.sv
`timescale 1ns/1ps
`default_nettype none

module bitmap_expander import line_pkg::*; (
   input  wire                    wr_clk,
   input  wire                    reset_n,
   input  wire                    start,
   input  wire [addr_w-1:0]       addr,
   input  wire line_word_t        data,
   input  wire [bm_idx_w-1:0]     first,
   input  wire [bm_idx_w-1:0]     last,
   input  wire [pix_w-1:0]        on_color,
   input  wire [pix_w-1:0]        off_color,
   output logic                   active,
   output logic                   pix_valid,
   output logic [addr_w-1:0]      pix_addr,
   output logic [pix_w-1:0]       pix_data
);

   logic [byte_w-1:0]   bits_q;
   logic [bm_idx_w-1:0] cur_q;     // One above the bit being emitted.
   logic [bm_idx_w-1:0] last_q;
   logic [2:0]          bit_idx;
   logic [pix_w-1:0]    on_q;
   logic [pix_w-1:0]    off_q;
   logic [addr_w-1:0]   addr_q;

   assign active    = (cur_q != last_q);
   assign pix_valid = active;  // One pixel every active cycle.
   assign bit_idx   = cur_q[2:0] - 1'b1;
   assign pix_addr  = addr_q;
   assign pix_data  = bits_q[bit_idx] ? on_q : off_q;

   always_ff @(posedge wr_clk) begin
      if (!reset_n) begin
         cur_q  <= '0;
         last_q <= '0;
      end else if (start) begin
         cur_q  <= first;
         last_q <= last;
      end else if (active) begin
         cur_q <= cur_q - 1'b1;  // Walk toward last.
      end
   end

   always_ff @(posedge wr_clk) begin
      if (start) begin
         bits_q <= data.bitmap.bits;
         on_q   <= on_color;
         off_q  <= off_color;
         addr_q <= addr;
      end else if (active) begin
         addr_q <= addr_q + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: rtl/line_pkg.sv
`default_nettype none

package line_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Line geometry and field widths
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam int line_len = 1280;  // Pixels per scanline.
   localparam int addr_w   = 11;
   localparam int pix_w    = 8;     // Colour index.
   localparam int word_w   = 16;    // Incoming write word.
   localparam int byte_w   = 8;
   localparam int nib_w    = 4;
   localparam int nib_cnt  = 4;     // Nibbles per tile word.
   localparam int pal_w    = 4;
   localparam int bm_idx_w = 4;     // Bitmap bit range, 0..8.
   localparam int tl_idx_w = 3;     // Tile pixel range, 0..4.

   // One write word, seen as a bitmap byte or as four tile nibbles.
   typedef union packed {
      struct packed {
         logic [word_w-byte_w-1:0] unused;
         logic [byte_w-1:0]        bits;  // Pixel bits, msb first.
      } bitmap;
      logic [nib_cnt-1:0][nib_w-1:0] nib;  // nib[0] is leftmost.
   } line_word_t;

   typedef enum logic [1:0] {
      mode_idle,
      mode_direct,
      mode_bitmap,
      mode_tile
   } wr_mode_t;

endpackage

`default_nettype wire

// File: rtl/line_ram.sv
`timescale 1ns/1ps
`default_nettype none

module line_ram import line_pkg::*; (
   input  wire                    wr_clk,
   input  wire                    wr_en,
   input  wire [addr_w-1:0]       wr_addr,
   input  wire [pix_w-1:0]        wr_data,
   input  wire                    rd_clk,
   input  wire [addr_w-1:0]       rd_addr,
   output logic [pix_w-1:0]       rd_data
);

   logic [pix_w-1:0] mem [line_len];

   // Write side in the fetcher clock domain.
   always_ff @(posedge wr_clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // Read side in the scan-out clock domain.
   always_ff @(posedge rd_clk) begin
      rd_data <= mem[rd_addr];  // Registered read.
   end

endmodule

`default_nettype wire

// File: rtl/line_render_top.sv
`timescale 1ns/1ps
`default_nettype none

module line_render_top import line_pkg::*; (
   input  wire                    reset_n,
   input  wire                    wr_clk,
   input  wire                    rd_clk,
   input  wire [addr_w-1:0]       rd_addr,
   input  wire                    wr_en,
   input  wire [addr_w-1:0]       wr_addr,
   input  wire line_word_t        wr_data,
   input  wire [pix_w-1:0]        wr_bitmap_on,
   input  wire [pix_w-1:0]        wr_bitmap_off,
   input  wire [bm_idx_w-1:0]     wr_bitmap_first,
   input  wire [bm_idx_w-1:0]     wr_bitmap_last,
   input  wire [tl_idx_w-1:0]     wr_tile_pixel_first,
   input  wire [tl_idx_w-1:0]     wr_tile_pixel_last,
   input  wire [pal_w-1:0]        wr_tile_palette,
   output logic [pix_w-1:0]       rd_data,
   output logic                   wr_busy
);

   logic              bm_start;
   logic              bm_active;
   logic              bm_pix_valid;
   logic [addr_w-1:0] bm_pix_addr;
   logic [pix_w-1:0]  bm_pix_data;
   logic              tl_start;
   logic              tl_active;
   logic              tl_pix_valid;
   logic [addr_w-1:0] tl_pix_addr;
   logic [pix_w-1:0]  tl_pix_data;
   logic              ram_wr_en;
   logic [addr_w-1:0] ram_wr_addr;
   logic [pix_w-1:0]  ram_wr_data;

   line_write_ctrl u_ctrl (
      .wr_clk              (wr_clk),
      .reset_n             (reset_n),
      .wr_en               (wr_en),
      .wr_addr             (wr_addr),
      .wr_data             (wr_data),
      .wr_bitmap_first     (wr_bitmap_first),
      .wr_tile_pixel_first (wr_tile_pixel_first),
      .bm_active           (bm_active),
      .bm_pix_valid        (bm_pix_valid),
      .bm_pix_addr         (bm_pix_addr),
      .bm_pix_data         (bm_pix_data),
      .tl_active           (tl_active),
      .tl_pix_valid        (tl_pix_valid),
      .tl_pix_addr         (tl_pix_addr),
      .tl_pix_data         (tl_pix_data),
      .bm_start            (bm_start),
      .tl_start            (tl_start),
      .ram_wr_en           (ram_wr_en),
      .ram_wr_addr         (ram_wr_addr),
      .ram_wr_data         (ram_wr_data),
      .wr_busy             (wr_busy)
   );

   bitmap_expander u_bitmap (
      .wr_clk    (wr_clk),
      .reset_n   (reset_n),
      .start     (bm_start),
      .addr      (wr_addr),
      .data      (wr_data),
      .first     (wr_bitmap_first),
      .last      (wr_bitmap_last),
      .on_color  (wr_bitmap_on),
      .off_color (wr_bitmap_off),
      .active    (bm_active),
      .pix_valid (bm_pix_valid),
      .pix_addr  (bm_pix_addr),
      .pix_data  (bm_pix_data)
   );

   tile_expander u_tile (
      .wr_clk    (wr_clk),
      .reset_n   (reset_n),
      .start     (tl_start),
      .addr      (wr_addr),
      .data      (wr_data),
      .first     (wr_tile_pixel_first),
      .last      (wr_tile_pixel_last),
      .palette   (wr_tile_palette),
      .active    (tl_active),
      .pix_valid (tl_pix_valid),
      .pix_addr  (tl_pix_addr),
      .pix_data  (tl_pix_data)
   );

   line_ram u_ram (
      .wr_clk  (wr_clk),
      .wr_en   (ram_wr_en),
      .wr_addr (ram_wr_addr),
      .wr_data (ram_wr_data),
      .rd_clk  (rd_clk),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

`default_nettype wire

// File: rtl/line_write_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module line_write_ctrl import line_pkg::*; (
   input  wire                    wr_clk,
   input  wire                    reset_n,
   input  wire                    wr_en,
   input  wire [addr_w-1:0]       wr_addr,
   input  wire line_word_t        wr_data,
   input  wire [bm_idx_w-1:0]     wr_bitmap_first,
   input  wire [tl_idx_w-1:0]     wr_tile_pixel_first,
   input  wire                    bm_active,
   input  wire                    bm_pix_valid,
   input  wire [addr_w-1:0]       bm_pix_addr,
   input  wire [pix_w-1:0]        bm_pix_data,
   input  wire                    tl_active,
   input  wire                    tl_pix_valid,
   input  wire [addr_w-1:0]       tl_pix_addr,
   input  wire [pix_w-1:0]        tl_pix_data,
   output logic                   bm_start,
   output logic                   tl_start,
   output logic                   ram_wr_en,
   output logic [addr_w-1:0]      ram_wr_addr,
   output logic [pix_w-1:0]       ram_wr_data,
   output logic                   wr_busy
);

   wr_mode_t mode;
   wr_mode_t cmd_mode;
   logic     accept;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Command acceptance
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign wr_busy = (mode == mode_bitmap) || (mode == mode_tile);
   assign accept  = wr_en && !wr_busy;  // Back-pressure.

   always_comb begin
      if (wr_bitmap_first != '0) begin
         cmd_mode = mode_bitmap;
      end else if (wr_tile_pixel_first != '0) begin
         cmd_mode = mode_tile;
      end else begin
         cmd_mode = mode_direct;
      end
   end

   assign bm_start = accept && (cmd_mode == mode_bitmap);
   assign tl_start = accept && (cmd_mode == mode_tile);

   always_ff @(posedge wr_clk) begin
      if (!reset_n) begin
         mode <= mode_idle;
      end else if (accept) begin
         mode <= cmd_mode;
      end else begin
         case (mode)
            mode_direct: mode <= mode_idle;
            mode_bitmap: if (!bm_active) mode <= mode_idle;  // Expander drained.
            mode_tile:   if (!tl_active) mode <= mode_idle;
            default:     mode <= mode_idle;
         endcase
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // RAM write port through one register stage
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge wr_clk) begin
      if (!reset_n) begin
         ram_wr_en <= 1'b0;
      end else begin
         ram_wr_en <= (accept && cmd_mode == mode_direct) ||
                      (mode == mode_bitmap && bm_pix_valid) ||
                      (mode == mode_tile && tl_pix_valid);
      end
   end

   always_ff @(posedge wr_clk) begin
      if (accept && cmd_mode == mode_direct) begin
         ram_wr_addr <= wr_addr;
         ram_wr_data <= wr_data.bitmap.bits;  // Low byte is the index.
      end else if (mode == mode_bitmap) begin
         ram_wr_addr <= bm_pix_addr;
         ram_wr_data <= bm_pix_data;
      end else if (mode == mode_tile) begin
         ram_wr_addr <= tl_pix_addr;
         ram_wr_data <= tl_pix_data;
      end
   end

endmodule

`default_nettype wire

// File: rtl/tile_expander.sv
`timescale 1ns/1ps
`default_nettype none

module tile_expander import line_pkg::*; (
   input  wire                    wr_clk,
   input  wire                    reset_n,
   input  wire                    start,
   input  wire [addr_w-1:0]       addr,
   input  wire line_word_t        data,
   input  wire [tl_idx_w-1:0]     first,
   input  wire [tl_idx_w-1:0]     last,
   input  wire [pal_w-1:0]        palette,
   output logic                   active,
   output logic                   pix_valid,
   output logic [addr_w-1:0]      pix_addr,
   output logic [pix_w-1:0]       pix_data
);

   line_word_t          tile_q;
   logic [tl_idx_w-1:0] cur_q;
   logic [tl_idx_w-1:0] last_q;
   logic [tl_idx_w-1:0] skip_q;    // Leading nibbles still to drop.
   logic [pal_w-1:0]    pal_q;
   logic [addr_w-1:0]   addr_q;

   assign active    = (cur_q != last_q);
   assign pix_valid = active && (skip_q == '0);
   assign pix_addr  = addr_q;
   assign pix_data  = {pal_q, tile_q.nib[0]};  // Palette in the high nibble.

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Pixel counters
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge wr_clk) begin
      if (!reset_n) begin
         cur_q  <= '0;
         last_q <= '0;
         skip_q <= '0;
      end else if (start) begin
         cur_q  <= first;
         last_q <= last;
         skip_q <= tl_idx_w'(nib_cnt) - first;
      end else if (active) begin
         if (skip_q != '0) begin
            skip_q <= skip_q - 1'b1;  // Dropped without a write.
         end else begin
            cur_q <= cur_q - 1'b1;
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Nibble shifter
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge wr_clk) begin
      if (start) begin
         tile_q <= data;
         pal_q  <= palette;
         addr_q <= addr;
      end else if (active) begin
         tile_q.nib <= {nib_w'(0), tile_q.nib[nib_cnt-1:1]};  // Next nibble down.
         if (skip_q == '0) begin
            addr_q <= addr_q + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog.f
rtl/line_pkg.sv
rtl/line_ram.sv
rtl/bitmap_expander.sv
rtl/tile_expander.sv
rtl/line_write_ctrl.sv
rtl/line_render_top.sv
dv/tb_clock_gen.sv
dv/line_render_tb.sv
